//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMipsCore
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard design/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] encodeRType(input logic [5:0] fn, input int rs, input int rt,
		input int rd, input int sh);
	return {cpuPkg::opSpecial, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

function automatic logic [31:0] encodeIType(input logic [5:0] op, input int rs, input int rt,
		input logic [31:0] imm);
	return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

// Fixed instruction template, only immediates and data words come from the LFSR
task automatic buildProgram();
	int i;
	for (i = 0; i < 256; i++)
		dmem[i] = randBits(32);
	for (i = 0; i < 256; i++)
		imem[i] = 32'h0;
	// ALU and immediate chain with distances 1 to 3, r2 is negative
	imem[0] = encodeIType(cpuPkg::opLui, 0, 1, randBits(16));
	imem[1] = encodeIType(cpuPkg::opOri, 1, 1, randBits(16));
	imem[2] = encodeIType(cpuPkg::opAddiu, 0, 2, randBits(15) | 32'h8000);
	imem[3] = encodeIType(cpuPkg::opAddiu, 0, 3, randBits(16));
	imem[4] = encodeRType(cpuPkg::fnSlt, 2, 3, 4, 0);
	imem[5] = encodeRType(cpuPkg::fnSlt, 3, 2, 5, 0);
	imem[6] = encodeRType(cpuPkg::fnAddu, 1, 3, 6, 0);
	imem[7] = encodeRType(cpuPkg::fnSubu, 6, 2, 7, 0);
	imem[8] = encodeRType(cpuPkg::fnAnd, 7, 1, 8, 0);
	imem[9] = encodeRType(cpuPkg::fnOr, 8, 6, 9, 0);
	imem[10] = encodeRType(cpuPkg::fnXor, 9, 4, 10, 0);
	imem[11] = encodeRType(cpuPkg::fnSll, 0, 10, 11, randBits(5));
	// Stores of fresh results, then loads with an immediate user
	imem[12] = encodeIType(cpuPkg::opAddiu, 0, 12, randBits(7) << 2);
	imem[13] = encodeIType(cpuPkg::opSw, 12, 11, 0);
	imem[14] = encodeRType(cpuPkg::fnAddu, 11, 5, 13, 0);
	imem[15] = encodeIType(cpuPkg::opSw, 12, 13, 4);
	imem[16] = encodeIType(cpuPkg::opLw, 12, 14, 0);
	imem[17] = encodeRType(cpuPkg::fnAddu, 14, 1, 15, 0);
	// Taken BEQ on a just-loaded register, then untaken BNE and taken BNE
	imem[18] = encodeIType(cpuPkg::opLw, 12, 16, 4);
	imem[19] = encodeIType(cpuPkg::opBeq, 16, 13, 3);
	imem[20] = encodeIType(cpuPkg::opAddiu, 16, 17, randBits(16));
	imem[21] = encodeIType(cpuPkg::opAddiu, 0, 18, 1);
	imem[22] = encodeIType(cpuPkg::opAddiu, 0, 19, 2);
	imem[23] = encodeIType(cpuPkg::opBne, 16, 13, 5);
	imem[24] = encodeIType(cpuPkg::opAddiu, 16, 20, randBits(16) | 32'h1);
	imem[25] = encodeIType(cpuPkg::opBne, 20, 16, 2);
	imem[26] = encodeRType(cpuPkg::fnSubu, 20, 3, 21, 0);
	imem[27] = encodeIType(cpuPkg::opAddiu, 0, 22, 7);
	// Branch while the load sits in memory, with a write to r0 in between
	imem[28] = encodeIType(cpuPkg::opLw, 0, 23, randBits(8) << 2);
	imem[29] = encodeIType(cpuPkg::opAddiu, 3, 0, randBits(16));
	imem[30] = encodeIType(cpuPkg::opBeq, 23, 0, 2);
	imem[31] = encodeRType(cpuPkg::fnXor, 23, 2, 24, 0);
	imem[32] = encodeRType(cpuPkg::fnAddu, 24, 23, 25, 0);
	imem[33] = encodeRType(cpuPkg::fnSlt, 25, 2, 26, 0);
	imem[34] = encodeIType(cpuPkg::opSw, 12, 26, 8);
	// Final self loop, its delay slot is the nop at 36
	imem[35] = encodeIType(cpuPkg::opBeq, 0, 0, 32'hffff);
	progEnd = 35;
	progLen = 37;
endtask

`endif

//--- bench/tbMipsCore.sv
`timescale 1ns/10ps

module tbMipsCore;

	localparam logic [31:0] resetPc = 32'hbfc0_0000;

	logic clk = 1'b0;
	logic rstN;
	logic instEn;
	logic [31:0] instAddr, instRdata;
	logic dataEn;
	logic [3:0] dataWen;
	logic [31:0] dataAddr, dataWdata, dataRdata;
	logic [31:0] debugWbPc, debugWbRfWdata;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] modelMem [0:255];
	logic [15:0] lfsr;
	int progLen, progEnd;

	// Writes and stores predicted by the reference model, in program order
	logic [31:0] wrPc [0:63];
	logic [4:0] wrNum [0:63];
	logic [31:0] wrData [0:63];
	logic [31:0] stAddr [0:63];
	logic [31:0] stData [0:63];
	int wrCount = 0, stCount = 0, wrIdx = 0, stIdx = 0;
	int cycle = 0, idleCycles = 0;
	logic modelReady = 1'b0, modelReached = 1'b0;
	logic wbSeen, storeSeen;

	mipsCore #(.resetPc(resetPc)) UUT (
		.clk(clk), .rstN(rstN), .instEn(instEn), .instAddr(instAddr), .instRdata(instRdata),
		.dataEn(dataEn), .dataWen(dataWen), .dataAddr(dataAddr), .dataWdata(dataWdata),
		.dataRdata(dataRdata), .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	always #20 clk = ~clk;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		failRun($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic nextLfsrBit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		int i;
		v = 32'h0;
		for (i = 0; i < n; i++)
			v = {v[30:0], nextLfsrBit()};
		return v;
	endfunction

	function automatic int pcIndex(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - resetPc;
		return {24'h0, offset[9:2]};
	endfunction

	function automatic int wordIdx(input logic [31:0] addr);
		return {24'h0, addr[9:2]};
	endfunction

	`include "tbProgram.svh"

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model, one instruction at a time with a single delay slot
	task automatic runModel();
		logic [31:0] regs [0:31];
		logic [31:0] pc, npc, nnpc, ins, a, b, imm, res, endPc;
		logic [4:0] rs, rt, rd;
		logic wr;
		int i;
		int steps;
		for (i = 0; i < 32; i++)
			regs[i] = 32'h0;
		for (i = 0; i < 256; i++)
			modelMem[i] = dmem[i];
		pc = resetPc;
		npc = resetPc + 32'd4;
		endPc = resetPc + 32'(progEnd * 4);
		steps = 0;
		while (pc != endPc && steps < 1000) begin
			ins = imem[pcIndex(pc)];
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			a = regs[rs];
			b = regs[rt];
			imm = {{16{ins[15]}}, ins[15:0]};
			nnpc = npc + 32'd4;
			wr = 1'b1;
			res = 32'h0;
			case (ins[31:26])
				cpuPkg::opSpecial: begin
					case (ins[5:0])
						cpuPkg::fnAddu: res = a + b;
						cpuPkg::fnSubu: res = a - b;
						cpuPkg::fnAnd:  res = a & b;
						cpuPkg::fnOr:   res = a | b;
						cpuPkg::fnXor:  res = a ^ b;
						cpuPkg::fnSlt:  res = {31'h0, $signed(a) < $signed(b)};
						cpuPkg::fnSll:  res = b << ins[10:6];
						default:        wr = 1'b0;
					endcase
				end
				cpuPkg::opAddiu: begin
					res = a + imm;
					rd = rt;
				end
				cpuPkg::opOri: begin
					res = a | {16'h0, ins[15:0]};
					rd = rt;
				end
				cpuPkg::opLui: begin
					res = {ins[15:0], 16'h0};
					rd = rt;
				end
				cpuPkg::opLw: begin
					res = modelMem[wordIdx(a + imm)];
					rd = rt;
				end
				cpuPkg::opSw: begin
					wr = 1'b0;
					stAddr[stCount] = a + imm;
					stData[stCount] = b;
					modelMem[wordIdx(a + imm)] = b;
					stCount++;
				end
				cpuPkg::opBeq: begin
					wr = 1'b0;
					if (a == b)
						nnpc = pc + 32'd4 + (imm << 2);
				end
				cpuPkg::opBne: begin
					wr = 1'b0;
					if (a != b)
						nnpc = pc + 32'd4 + (imm << 2);
				end
				default: wr = 1'b0;
			endcase
			if (wr && rd != 5'd0) begin
				regs[rd] = res;
				wrPc[wrCount] = pc;
				wrNum[wrCount] = rd;
				wrData[wrCount] = res;
				wrCount++;
			end
			pc = npc;
			npc = nnpc;
			steps++;
		end
		modelReached = (pc == endPc);
	endtask

	initial begin
		rstN = 1'b0;
		instRdata = 32'h0;
		dataRdata = 32'h0;
		lfsr = 16'd12;
		buildProgram();
		runModel();
		modelReady = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// SRAM models, both answer 1 ns after the edge
	always @(posedge clk) begin
		#1;
		instRdata = imem[pcIndex(instAddr)];
	end

	always @(posedge clk) begin : dataSram
		logic [31:0] rd;
		rd = dataRdata;
		if (dataEn && dataWen != 4'h0)
			dmem[wordIdx(dataAddr)] = dataWdata;
		else if (dataEn)
			rd = dmem[wordIdx(dataAddr)];
		#1;
		dataRdata = rd;
	end

	assign wbSeen = debugWbRfWen != 4'h0;
	assign storeSeen = dataEn && dataWen != 4'h0;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (rstN && wbSeen)
			wrIdx <= wrIdx + 1;
		if (rstN && storeSeen)
			stIdx <= stIdx + 1;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Checks
	assert property (@(posedge clk) !rstN && cycle > 0 |-> !instEn && !dataEn
			&& debugWbRfWen == 4'h0)
		else failRun("SRAM strobe or trace write enable active during reset");
	assert property (@(posedge clk) $rose(rstN) |-> !instEn && !dataEn && debugWbRfWen == 4'h0)
		else failRun("SRAM strobe or trace write enable active right after reset");
	assert property (@(posedge clk) disable iff (!rstN) $rose(instEn) |-> instAddr == resetPc)
		else reportMismatch("instAddr", $sampled(instAddr), resetPc);

	assert property (@(posedge clk) disable iff (!rstN) wbSeen |-> wrIdx < wrCount)
		else failRun("register write-back that the reference model does not predict");
	assert property (@(posedge clk) disable iff (!rstN)
			wbSeen && wrIdx < wrCount |-> debugWbPc == wrPc[wrIdx])
		else reportMismatch("debugWbPc", $sampled(debugWbPc), $sampled(wrPc[wrIdx]));
	assert property (@(posedge clk) disable iff (!rstN)
			wbSeen && wrIdx < wrCount |-> debugWbRfWnum == wrNum[wrIdx])
		else reportMismatch("debugWbRfWnum", 32'($sampled(debugWbRfWnum)),
			32'($sampled(wrNum[wrIdx])));
	assert property (@(posedge clk) disable iff (!rstN)
			wbSeen && wrIdx < wrCount |-> debugWbRfWdata == wrData[wrIdx])
		else reportMismatch("debugWbRfWdata", $sampled(debugWbRfWdata),
			$sampled(wrData[wrIdx]));
	assert property (@(posedge clk) disable iff (!rstN)
			wbSeen && debugWbRfWnum == 5'd0 |-> debugWbRfWdata == 32'h0)
		else failRun("nonzero write-back data traced for register 0");

	assert property (@(posedge clk) disable iff (!rstN) storeSeen |-> stIdx < stCount)
		else failRun("store that the reference model does not predict");
	assert property (@(posedge clk) disable iff (!rstN)
			storeSeen && stIdx < stCount |-> dataAddr == stAddr[stIdx])
		else reportMismatch("dataAddr", $sampled(dataAddr), $sampled(stAddr[stIdx]));
	assert property (@(posedge clk) disable iff (!rstN)
			storeSeen && stIdx < stCount |-> dataWdata == stData[stIdx])
		else reportMismatch("dataWdata", $sampled(dataWdata), $sampled(stData[stIdx]));
	assert property (@(posedge clk) disable iff (!rstN) dataWen == 4'h0 || dataWen == 4'hf)
		else failRun("partial data write enable seen, only full-word stores exist");

	// The core spins on the final branch once the model's last write has been seen
	always @(posedge clk) begin
		if (modelReached && rstN && wrIdx == wrCount && stIdx == stCount) begin
			idleCycles <= idleCycles + 1;
			if (idleCycles == 8) begin
				$display("PASS: all tests");
				$finish;
			end
		end
	end

	initial begin : watchdog
		wait (modelReady);
		repeat (progLen * 4 + 200 + 10) @(posedge clk);
		failRun("timeout: the program did not finish within the watchdog limit");
	end

endmodule

//--- design/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
	input  logic [cpuPkg::dataW-1:0] a,
	input  logic [cpuPkg::dataW-1:0] b,
	input  logic [4:0] shamt,
	input  cpuPkg::aluOpE op,
	output logic [cpuPkg::dataW-1:0] result
);

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			cpuPkg::aluAdd: result = a + b;
			cpuPkg::aluSub: result = a - b;
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr:  result = a | b;
			cpuPkg::aluXor: result = a ^ b;
			cpuPkg::aluSlt: result = {{(cpuPkg::dataW-1){1'b0}}, lessThan};
			cpuPkg::aluSll: result = b << shamt;
			// Immediate goes to the top half, low half cleared
			cpuPkg::aluLui: result = {b[15:0], 16'h0000};
			default:        result = a + b;
		endcase
	end

endmodule

//--- design/cpuPkg.sv
package cpuPkg;

	localparam int dataW = 32;
	localparam int regAddrW = 5;

	// ~~~~~~~~~~~~~~~~~~~~
	// Instruction encodings
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	// Function field of SPECIAL instructions
	typedef enum logic [5:0] {
		fnSll  = 6'h00,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnSlt  = 6'h2a
	} functE;

	// ~~~~~~~~~~~~~~~~~~~~
	// Datapath controls
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluLui
	} aluOpE;

	typedef enum logic {
		wbAlu,
		wbMem
	} wbSrcE;

	// Where an operand comes from when a younger write is still in flight
	typedef enum logic [1:0] {
		fwdRegFile,
		fwdFromMem,
		fwdFromWb
	} fwdSelE;

endpackage

//--- design/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
	input  logic [cpuPkg::regAddrW-1:0] idRs,
	input  logic [cpuPkg::regAddrW-1:0] idRt,
	input  logic idIsBranch,
	input  logic [cpuPkg::regAddrW-1:0] exRs,
	input  logic [cpuPkg::regAddrW-1:0] exRt,
	input  logic [cpuPkg::regAddrW-1:0] exDest,
	input  logic exRegWr,
	input  logic exMemRd,
	input  logic [cpuPkg::regAddrW-1:0] memDest,
	input  logic memRegWr,
	input  logic memMemRd,
	wbBusIf.sink wb,
	output cpuPkg::fwdSelE fwdExA,
	output cpuPkg::fwdSelE fwdExB,
	output cpuPkg::fwdSelE fwdIdA,
	output cpuPkg::fwdSelE fwdIdB,
	output logic stall
);

	logic exHit;
	logic memLoadHit;

	function automatic logic hit(input logic [cpuPkg::regAddrW-1:0] dest, input logic wr,
			input logic [cpuPkg::regAddrW-1:0] src);
		return wr && dest != '0 && dest == src;
	endfunction

	// Memory stage is newer than write-back, so it is checked first
	function automatic cpuPkg::fwdSelE pick(input logic [cpuPkg::regAddrW-1:0] src,
			input logic memOk);
		if (hit(memDest, memRegWr && memOk, src))
			return cpuPkg::fwdFromMem;
		if (hit(wb.num, wb.wr, src))
			return cpuPkg::fwdFromWb;
		return cpuPkg::fwdRegFile;
	endfunction

	always_comb begin
		fwdExA = pick(exRs, 1'b1);
		fwdExB = pick(exRt, 1'b1);
		// Load data only exists once the load reaches write-back
		fwdIdA = pick(idRs, !memMemRd);
		fwdIdB = pick(idRt, !memMemRd);
	end

	assign exHit = hit(exDest, exRegWr, idRs) || hit(exDest, exRegWr, idRt);
	assign memLoadHit = hit(memDest, memRegWr && memMemRd, idRs)
		|| hit(memDest, memRegWr && memMemRd, idRt);

	// Branches compare in decode and must wait for any result still in execute
	assign stall = (exMemRd && exHit) || (idIsBranch && (exHit || memLoadHit));

	// The load-use stall one cycle earlier keeps a load out of the EX forward path
	always_comb begin
		if (memMemRd)
			assert final (fwdExA != cpuPkg::fwdFromMem && fwdExB != cpuPkg::fwdFromMem)
			else $error("memory-stage forward selected while memory holds a load");
	end

endmodule

//--- design/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
	input  logic [cpuPkg::dataW-1:0] instr,
	input  logic [cpuPkg::dataW-1:0] rsVal,
	input  logic [cpuPkg::dataW-1:0] rtVal,
	output cpuPkg::aluOpE aluOp,
	output logic useImm,
	output logic zeroExt,
	output logic regWr,
	output logic destIsRt,
	output logic memRd,
	output logic memWr,
	output logic isBranch,
	output cpuPkg::wbSrcE wbSrc,
	output logic branchTaken
);

	cpuPkg::opcodeE opcode;
	cpuPkg::functE funct;

	assign opcode = cpuPkg::opcodeE'(instr[31:26]);
	assign funct = cpuPkg::functE'(instr[5:0]);

	always_comb begin
		// Anything not listed below falls through as a no-op
		aluOp = cpuPkg::aluAdd;
		useImm = 1'b0;
		zeroExt = 1'b0;
		regWr = 1'b0;
		destIsRt = 1'b0;
		memRd = 1'b0;
		memWr = 1'b0;
		isBranch = 1'b0;
		wbSrc = cpuPkg::wbAlu;
		case (opcode)
			cpuPkg::opSpecial: begin
				regWr = 1'b1;
				case (funct)
					cpuPkg::fnAddu: aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSubu: aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd:  aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOr:   aluOp = cpuPkg::aluOr;
					cpuPkg::fnXor:  aluOp = cpuPkg::aluXor;
					cpuPkg::fnSlt:  aluOp = cpuPkg::aluSlt;
					cpuPkg::fnSll:  aluOp = cpuPkg::aluSll;
					default:        regWr = 1'b0;
				endcase
			end
			cpuPkg::opAddiu: begin
				useImm = 1'b1;
				regWr = 1'b1;
				destIsRt = 1'b1;
			end
			cpuPkg::opOri: begin
				aluOp = cpuPkg::aluOr;
				useImm = 1'b1;
				zeroExt = 1'b1;
				regWr = 1'b1;
				destIsRt = 1'b1;
			end
			cpuPkg::opLui: begin
				aluOp = cpuPkg::aluLui;
				useImm = 1'b1;
				regWr = 1'b1;
				destIsRt = 1'b1;
			end
			cpuPkg::opLw: begin
				useImm = 1'b1;
				regWr = 1'b1;
				destIsRt = 1'b1;
				memRd = 1'b1;
				wbSrc = cpuPkg::wbMem;
			end
			cpuPkg::opSw: begin
				useImm = 1'b1;
				memWr = 1'b1;
			end
			cpuPkg::opBeq, cpuPkg::opBne: isBranch = 1'b1;
			default: ;
		endcase
	end

	// BEQ wants equal operands and BNE wants them different
	assign branchTaken = isBranch && ((opcode == cpuPkg::opBeq) == (rsVal == rtVal));

endmodule

//--- design/mipsCore.sv
`timescale 1ns/10ps

module mipsCore #(
	parameter logic [31:0] resetPc = 32'hbfc0_0000
) (
	input  logic clk,
	input  logic rstN,
	output logic instEn,
	output logic [cpuPkg::dataW-1:0] instAddr,
	input  logic [cpuPkg::dataW-1:0] instRdata,
	output logic dataEn,
	output logic [3:0] dataWen,
	output logic [cpuPkg::dataW-1:0] dataAddr,
	output logic [cpuPkg::dataW-1:0] dataWdata,
	input  logic [cpuPkg::dataW-1:0] dataRdata,
	output logic [cpuPkg::dataW-1:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [cpuPkg::regAddrW-1:0] debugWbRfWnum,
	output logic [cpuPkg::dataW-1:0] debugWbRfWdata
);

	localparam int dW = cpuPkg::dataW;
	localparam int aW = cpuPkg::regAddrW;

	logic [dW-1:0] pc;
	logic fetchOn;
	logic [dW-1:0] idInstr, idPc;
	logic [aW-1:0] idRs, idRt, idDest;
	logic [dW-1:0] rfRs, rfRt, idRsVal, idRtVal, idSext, idImm32, branchTarget;
	cpuPkg::aluOpE decAluOp;
	cpuPkg::wbSrcE decWbSrc;
	logic decUseImm, decZeroExt, decRegWr, decDestIsRt, decMemRd, decMemWr, decIsBranch;
	logic branchTaken, stall;
	cpuPkg::fwdSelE fwdExA, fwdExB, fwdIdA, fwdIdB;

	logic [dW-1:0] exPc, exRsVal, exRtVal, exImm, exA, exB, exRtFwd, exResult;
	logic [aW-1:0] exRs, exRt, exDest;
	logic [4:0] exShamt;
	logic exRegWr, exMemRd, exMemWr, exUseImm;
	cpuPkg::aluOpE exAluOp;
	cpuPkg::wbSrcE exWbSrc;

	logic [dW-1:0] memPc, memResult;
	logic [aW-1:0] memDest;
	logic memRegWr, memMemRd;
	cpuPkg::wbSrcE memWbSrc;

	wbBusIf wb ();

	function automatic logic [dW-1:0] fwdMux(input cpuPkg::fwdSelE sel, input logic [dW-1:0] rf,
			input logic [dW-1:0] memV, input logic [dW-1:0] wbV);
		case (sel)
			cpuPkg::fwdFromMem: return memV;
			cpuPkg::fwdFromWb:  return wbV;
			default:            return rf;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Fetch holds off for one cycle after reset so resetPc is fetched first
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
			fetchOn <= 1'b0;
		end else begin
			fetchOn <= 1'b1;
			if (fetchOn && !stall)
				pc <= branchTaken ? branchTarget : pc + 32'd4;
		end
	end

	assign instEn = fetchOn;
	assign instAddr = pc;

	always_ff @(posedge clk) begin
		if (!rstN)
			idInstr <= '0;
		else if (!stall)
			idInstr <= fetchOn ? instRdata : '0;
		if (!stall)
			idPc <= pc;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Decode
	assign idRs = idInstr[25:21];
	assign idRt = idInstr[20:16];
	assign idDest = decDestIsRt ? idRt : idInstr[15:11];
	assign idSext = {{16{idInstr[15]}}, idInstr[15:0]};
	assign idImm32 = decZeroExt ? {16'h0000, idInstr[15:0]} : idSext;
	// The delay slot sits at idPc + 4, the offset counts from there
	assign branchTarget = idPc + 32'd4 + {idSext[29:0], 2'b00};
	assign idRsVal = fwdMux(fwdIdA, rfRs, memResult, wb.data);
	assign idRtVal = fwdMux(fwdIdB, rfRt, memResult, wb.data);

	regFile uRegFile (
		.clk(clk), .rstN(rstN), .rsAddr(idRs), .rtAddr(idRt),
		.rsData(rfRs), .rtData(rfRt), .wb(wb.sink)
	);

	instrDecoder uDecoder (
		.instr(idInstr), .rsVal(idRsVal), .rtVal(idRtVal), .aluOp(decAluOp),
		.useImm(decUseImm), .zeroExt(decZeroExt), .regWr(decRegWr), .destIsRt(decDestIsRt),
		.memRd(decMemRd), .memWr(decMemWr), .isBranch(decIsBranch), .wbSrc(decWbSrc),
		.branchTaken(branchTaken)
	);

	hazardUnit uHazard (
		.idRs(idRs), .idRt(idRt), .idIsBranch(decIsBranch),
		.exRs(exRs), .exRt(exRt), .exDest(exDest), .exRegWr(exRegWr), .exMemRd(exMemRd),
		.memDest(memDest), .memRegWr(memRegWr), .memMemRd(memMemRd), .wb(wb.sink),
		.fwdExA(fwdExA), .fwdExB(fwdExB), .fwdIdA(fwdIdA), .fwdIdB(fwdIdB), .stall(stall)
	);

	// A stall sends a bubble into execute, writes to register 0 are dropped here
	always_ff @(posedge clk) begin
		if (!rstN || stall) begin
			exRegWr <= 1'b0;
			exMemRd <= 1'b0;
			exMemWr <= 1'b0;
			// A bubble reads no registers, so it never asks for a forward
			exRs <= '0;
			exRt <= '0;
		end else begin
			exRegWr <= decRegWr && idDest != '0;
			exMemRd <= decMemRd;
			exMemWr <= decMemWr;
			exRs <= idRs;
			exRt <= idRt;
		end
		exPc <= idPc;
		exAluOp <= decAluOp;
		exUseImm <= decUseImm;
		exWbSrc <= decWbSrc;
		exDest <= idDest;
		exRsVal <= idRsVal;
		exRtVal <= idRtVal;
		exImm <= idImm32;
		exShamt <= idInstr[10:6];
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Execute and the data SRAM request
	assign exA = fwdMux(fwdExA, exRsVal, memResult, wb.data);
	assign exRtFwd = fwdMux(fwdExB, exRtVal, memResult, wb.data);
	assign exB = exUseImm ? exImm : exRtFwd;

	aluUnit uAlu (
		.a(exA), .b(exB), .shamt(exShamt), .op(exAluOp), .result(exResult)
	);

	assign dataEn = exMemRd || exMemWr;
	assign dataWen = {4{exMemWr}};
	assign dataAddr = exResult;
	assign dataWdata = exRtFwd;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memRegWr <= 1'b0;
			memMemRd <= 1'b0;
		end else begin
			memRegWr <= exRegWr;
			memMemRd <= exMemRd;
		end
		memPc <= exPc;
		memDest <= exDest;
		memWbSrc <= exWbSrc;
		memResult <= exResult;
	end

	// Load data arrives from the SRAM during the memory cycle
	always_ff @(posedge clk) begin
		if (!rstN)
			wb.wr <= 1'b0;
		else
			wb.wr <= memRegWr;
		wb.num <= memDest;
		wb.pc <= memPc;
		wb.data <= (memWbSrc == cpuPkg::wbMem) ? dataRdata : memResult;
	end

	assign debugWbPc = wb.pc;
	assign debugWbRfWen = {4{wb.wr}};
	assign debugWbRfWnum = wb.num;
	assign debugWbRfWdata = wb.data;

	// ~~~~~~~~~~~~~~~~~~~~
	// Strobes must be quiet in the cycle after any edge that saw reset
	assert property (@(posedge clk) !rstN |=> !instEn && !dataEn)
		else $error("SRAM strobe active during reset");

	assert property (@(posedge clk) disable iff (!rstN) dataWen != '0 |-> dataEn)
		else $error("data write enable without data strobe");

endmodule

//--- design/regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic clk,
	input  logic rstN,
	input  logic [cpuPkg::regAddrW-1:0] rsAddr,
	input  logic [cpuPkg::regAddrW-1:0] rtAddr,
	output logic [cpuPkg::dataW-1:0] rsData,
	output logic [cpuPkg::dataW-1:0] rtData,
	wbBusIf.sink wb
);

	// Register 0 has no storage
	logic [cpuPkg::dataW-1:0] regs [1:(1 << cpuPkg::regAddrW)-1];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < (1 << cpuPkg::regAddrW); i++)
				regs[i] <= '0;
		end else if (wb.wr && wb.num != '0) begin
			regs[wb.num] <= wb.data;
		end
	end

	// A write in this cycle is seen by a read of the same register
	function automatic logic [cpuPkg::dataW-1:0] readPort(input logic [cpuPkg::regAddrW-1:0] addr);
		if (addr == '0)
			return '0;
		if (wb.wr && wb.num == addr)
			return wb.data;
		return regs[addr];
	endfunction

	always_comb begin
		rsData = readPort(rsAddr);
		rtData = readPort(rtAddr);
	end

endmodule

//--- design/wbBusIf.sv
`timescale 1ns/10ps

interface wbBusIf;

	logic wr;
	logic [cpuPkg::regAddrW-1:0] num;
	logic [cpuPkg::dataW-1:0] data;
	logic [cpuPkg::dataW-1:0] pc;

	// Driven from the write-back stage register
	modport source(output wr, num, data, pc);

	modport sink(input wr, num, data, pc);

endinterface

//--- project.f
+incdir+bench
design/cpuPkg.sv
design/wbBusIf.sv
design/instrDecoder.sv
design/regFile.sv
design/hazardUnit.sv
design/aluUnit.sv
design/mipsCore.sv
bench/tbMipsCore.sv
